// ==== chessUserInput.f ====
src/chessPkg.sv
src/cursorControl.sv
src/moveSelect.sv
src/boardWriter.sv
src/chessUserInput.sv
tests/chessUserInput_sva.sv
tests/chessUserInputTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the chessUserInput testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module chessUserInputTb -f chessUserInput.f

./obj_dir/VchessUserInputTb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation passed"

// ==== src/boardWriter.sv ====
`timescale 1ns/1ps

module boardWriter (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            commitValid,
    input  logic [chessPkg::squareBits-1:0] commitTarget,
    input  logic [chessPkg::squareBits-1:0] commitSource,
    input  logic [chessPkg::pieceBits-1:0]  commitContent,
    output logic [chessPkg::changeBits-1:0] changePiece,
    output logic                            writeDone
);
    import chessPkg::*;

    localparam logic [1:0] stIdle    = 2'd0;
    localparam logic [1:0] stClear   = 2'd1;
    localparam logic [1:0] stRelease = 2'd2;

    logic [1:0]            step;
    logic [squareBits-1:0] sourceSquare;
    logic                  acceptMove;

    assign acceptMove = (step == stIdle) && commitValid;

    //////////////////////////////////////////////////
    // Write sequencer
    //////////////////////////////////////////////////

    // Place on target, then empty the source, then drop the strobe.
    // changePiece is {strobe, content, square}
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step        <= stIdle;
            changePiece <= '0;
            writeDone   <= 1'b0;
        end else begin
            writeDone <= 1'b0;
            case (step)
                stIdle: begin
                    if (commitValid) begin
                        changePiece <= {1'b1, commitContent, commitTarget};
                        step        <= stClear;
                    end
                end
                stClear: begin
                    changePiece <= {1'b1, 1'b0, kindEmpty, sourceSquare};
                    step        <= stRelease;
                end
                stRelease: begin
                    // Square and content stay, only the strobe falls
                    changePiece[changeBits-1] <= 1'b0;
                    writeDone                 <= 1'b1;
                    step                      <= stIdle;
                end
                default: begin
                    step <= stIdle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Source square held for the clear write
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (acceptMove) begin
            sourceSquare <= commitSource;
        end
    end

endmodule

// ==== src/chessPkg.sv ====
package chessPkg;

    //////////////////////////////////////////////////
    // Board geometry and word widths
    //////////////////////////////////////////////////

    // Square index is {file, rank}, three bits each
    localparam int squareBits   = 6;
    localparam int pieceBits    = 4;
    localparam int boardBits    = 256;
    localparam int changeBits   = 11;
    localparam int moveDataBits = 14;

    //////////////////////////////////////////////////
    // Piece kinds, colour sits above these as bit 3
    //////////////////////////////////////////////////

    localparam logic [2:0] kindEmpty  = 3'd0;
    localparam logic [2:0] kindKing   = 3'd1;
    localparam logic [2:0] kindQueen  = 3'd2;
    localparam logic [2:0] kindBishop = 3'd3;
    localparam logic [2:0] kindKnight = 3'd4;
    localparam logic [2:0] kindRook   = 3'd5;
    localparam logic [2:0] kindPawn   = 3'd6;

    // Cursor square after reset
    localparam logic [squareBits-1:0] defaultCursor = 6'd38;

    //////////////////////////////////////////////////
    // Square content
    //////////////////////////////////////////////////

    // Same four bits seen as a whole code or as colour plus kind.
    // isBlack follows playerTurn, black is 1
    typedef union packed {
        logic [pieceBits-1:0] raw;
        struct packed {
            logic       isBlack;
            logic [2:0] kind;
        } fields;
    } pieceCode;

endpackage

// ==== src/chessUserInput.sv ====
`timescale 1ns/1ps

module chessUserInput (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              allowMove,
    input  logic                              BTNC,
    input  logic                              BTNU,
    input  logic                              BTND,
    input  logic                              BTNR,
    input  logic                              BTNL,
    input  logic [chessPkg::boardBits-1:0]    entireBoard,
    output logic [chessPkg::changeBits-1:0]   changePiece,
    output logic [chessPkg::moveDataBits-1:0] moveData
);
    import chessPkg::*;

    logic [squareBits-1:0] cursorLocation;
    logic [squareBits-1:0] selectionLocation;
    logic [squareBits-1:0] commitTarget;
    logic [squareBits-1:0] commitSource;
    logic [pieceBits-1:0]  commitContent;
    logic                  commitValid;
    logic                  writeDone;
    logic                  selectionCheck;
    logic                  playerTurn;

    //////////////////////////////////////////////////
    // Cursor, move decision, board writes
    //////////////////////////////////////////////////

    cursorControl #(
        .startSquare(defaultCursor)
    ) cursorStage (
        .clk           (clk),
        .reset         (reset),
        .BTNU          (BTNU),
        .BTND          (BTND),
        .BTNR          (BTNR),
        .BTNL          (BTNL),
        .cursorLocation(cursorLocation)
    );

    moveSelect selectStage (
        .clk              (clk),
        .reset            (reset),
        .BTNC             (BTNC),
        .allowMove        (allowMove),
        .writeDone        (writeDone),
        .entireBoard      (entireBoard),
        .cursorLocation   (cursorLocation),
        .commitValid      (commitValid),
        .commitTarget     (commitTarget),
        .commitSource     (commitSource),
        .commitContent    (commitContent),
        .selectionCheck   (selectionCheck),
        .playerTurn       (playerTurn),
        .selectionLocation(selectionLocation)
    );

    boardWriter writeStage (
        .clk          (clk),
        .reset        (reset),
        .commitValid  (commitValid),
        .commitTarget (commitTarget),
        .commitSource (commitSource),
        .commitContent(commitContent),
        .changePiece  (changePiece),
        .writeDone    (writeDone)
    );

    // Snapshot for the rule checker and display, one cycle behind
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            moveData <= {1'b0, 1'b0, {squareBits{1'b0}}, defaultCursor};
        end else begin
            moveData <= {playerTurn, selectionCheck, selectionLocation, cursorLocation};
        end
    end

endmodule

// ==== src/cursorControl.sv ====
`timescale 1ns/1ps

module cursorControl #(
    parameter logic [chessPkg::squareBits-1:0] startSquare = '0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            BTNU,
    input  logic                            BTND,
    input  logic                            BTNR,
    input  logic                            BTNL,
    output logic [chessPkg::squareBits-1:0] cursorLocation
);
    import chessPkg::*;

    logic [2:0] fileIdx;
    logic [2:0] rankIdx;
    logic [squareBits-1:0] nextLocation;

    assign fileIdx = cursorLocation[5:3];
    assign rankIdx = cursorLocation[2:0];

    //////////////////////////////////////////////////
    // One step per clock, highest button wins
    //////////////////////////////////////////////////

    // A blocked step at an edge holds the cursor,
    // lower priority buttons do not get a turn then
    always_comb begin
        nextLocation = cursorLocation;
        if (BTNL) begin
            if (fileIdx != 3'd0) begin
                nextLocation = {fileIdx - 3'd1, rankIdx};
            end
        end else if (BTNR) begin
            if (fileIdx != 3'd7) begin
                nextLocation = {fileIdx + 3'd1, rankIdx};
            end
        end else if (BTND) begin
            if (rankIdx != 3'd7) begin
                nextLocation = {fileIdx, rankIdx + 3'd1};
            end
        end else if (BTNU) begin
            if (rankIdx != 3'd0) begin
                nextLocation = {fileIdx, rankIdx - 3'd1};
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursorLocation <= startSquare;
        end else begin
            cursorLocation <= nextLocation;
        end
    end

endmodule

// ==== src/moveSelect.sv ====
`timescale 1ns/1ps

module moveSelect (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            BTNC,
    input  logic                            allowMove,
    input  logic                            writeDone,
    input  logic [chessPkg::boardBits-1:0]  entireBoard,
    input  logic [chessPkg::squareBits-1:0] cursorLocation,
    output logic                            commitValid,
    output logic [chessPkg::squareBits-1:0] commitTarget,
    output logic [chessPkg::squareBits-1:0] commitSource,
    output logic [chessPkg::pieceBits-1:0]  commitContent,
    output logic                            selectionCheck,
    output logic                            playerTurn,
    output logic [chessPkg::squareBits-1:0] selectionLocation
);
    import chessPkg::*;

    localparam logic [1:0] stSelect = 2'd0;
    localparam logic [1:0] stMove   = 2'd1;
    localparam logic [1:0] stWait   = 2'd2;

    logic [1:0] state;
    pieceCode   cursorPiece;
    pieceCode   selectedPiece;
    pieceCode   placedPiece;
    logic       ownPiece;
    logic       promote;
    logic       doCommit;

    //////////////////////////////////////////////////
    // Square lookups
    //////////////////////////////////////////////////

    assign cursorPiece   = pieceCode'(entireBoard[{cursorLocation, 2'b00} +: pieceBits]);
    assign selectedPiece = pieceCode'(entireBoard[{selectionLocation, 2'b00} +: pieceBits]);

    // Something there and it belongs to the side to move
    assign ownPiece = (cursorPiece.fields.kind != kindEmpty)
                   && (cursorPiece.fields.isBlack == playerTurn);

    // White pawns run toward rank 0, black toward rank 7
    assign promote = ((selectedPiece.raw == {1'b0, kindPawn}) && (cursorLocation[2:0] == 3'd0))
                  || ((selectedPiece.raw == {1'b1, kindPawn}) && (cursorLocation[2:0] == 3'd7));

    always_comb begin
        placedPiece = selectedPiece;
        if (promote) begin
            // Colour bit stays, only the kind changes
            placedPiece.fields.kind = kindQueen;
        end
    end

    assign doCommit = (state == stMove) && BTNC && allowMove;

    //////////////////////////////////////////////////
    // Selection FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state             <= stSelect;
            selectionCheck    <= 1'b0;
            selectionLocation <= '0;
            playerTurn        <= 1'b0;
            commitValid       <= 1'b0;
        end else begin
            commitValid <= 1'b0;
            case (state)
                stSelect: begin
                    if (BTNC && ownPiece) begin
                        selectionCheck    <= 1'b1;
                        selectionLocation <= cursorLocation;
                        state             <= stMove;
                    end
                end
                stMove: begin
                    if (BTNC) begin
                        selectionCheck <= 1'b0;
                        if (allowMove) begin
                            commitValid <= 1'b1;
                            state       <= stWait;
                        end else begin
                            // Rejected move, back to picking a piece
                            state <= stSelect;
                        end
                    end
                end
                stWait: begin
                    // Buttons other than cursor ones are ignored here
                    if (writeDone) begin
                        playerTurn <= ~playerTurn;
                        state      <= stSelect;
                    end
                end
                default: begin
                    state <= stSelect;
                end
            endcase
        end
    end

    // Move payload, only meaningful while commitValid is high
    always_ff @(posedge clk) begin
        if (doCommit) begin
            commitTarget  <= cursorLocation;
            commitSource  <= selectionLocation;
            commitContent <= placedPiece.raw;
        end
    end

endmodule

// ==== tests/chessUserInputTb.sv ====
`timescale 1ns/1ps

module chessUserInputTb;
    import chessPkg::*;

    //////////////////////////////////////////////////
    // Run length, start square and button codes
    //////////////////////////////////////////////////

    localparam int scriptedCycles = 250;
    localparam int randomCycles   = 200;
    // Twice the scripted stretch plus the random stretch
    localparam int cycleLimit     = 2 * scriptedCycles + randomCycles;
    localparam logic [5:0] startCursor = 6'd38;

    // Button vectors are {C, U, D, R, L}
    localparam logic [4:0] btnC = 5'b10000;
    localparam logic [4:0] btnU = 5'b01000;
    localparam logic [4:0] btnD = 5'b00100;
    localparam logic [4:0] btnR = 5'b00010;
    localparam logic [4:0] btnL = 5'b00001;

    typedef struct packed {
        logic [1:0] fsm;      // 0 select, 1 move, 2 wait for writer
        logic [1:0] phase;    // 0 idle, 1 place write shown, 2 clear write shown
        logic       done;
        logic       commit;
        logic       turn;
        logic       sel;
        logic [5:0] selSq;
        logic [5:0] cursor;
        logic [5:0] target;
        logic [5:0] source;
        logic [3:0] content;
    } modelState;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    allowMove;
    logic                    BTNC;
    logic                    BTNU;
    logic                    BTND;
    logic                    BTNR;
    logic                    BTNL;
    logic [boardBits-1:0]    entireBoard;
    logic [changeBits-1:0]   changePiece;
    logic [moveDataBits-1:0] moveData;

    logic [boardBits-1:0]    boardModel;
    modelState               model;
    modelState               lastModel;
    logic [31:0]             lcgState;
    int                      errorCount = 0;
    int                      checkCount = 0;
    int                      cycleCount = 0;

    assign entireBoard = boardModel;

    chessUserInput UUT (
        .clk        (clk),
        .reset      (reset),
        .allowMove  (allowMove),
        .BTNC       (BTNC),
        .BTNU       (BTNU),
        .BTND       (BTND),
        .BTNR       (BTNR),
        .BTNL       (BTNL),
        .entireBoard(entireBoard),
        .changePiece(changePiece),
        .moveData   (moveData)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [3:0] squareContent(input logic [boardBits-1:0] board,
                                                 input logic [5:0] sq);
        return board[{sq, 2'b00} +: 4];
    endfunction

    function automatic logic [2:0] backRowKind(input logic [2:0] fileIdx);
        case (fileIdx)
            3'd0, 3'd7: return kindRook;
            3'd1, 3'd6: return kindKnight;
            3'd2, 3'd5: return kindBishop;
            3'd3:       return kindQueen;
            default:    return kindKing;
        endcase
    endfunction

    // Next expected state for one clock edge
    function automatic modelState predictNext(input modelState s, input logic [4:0] buttons,
                                              input logic allow,
                                              input logic [boardBits-1:0] board);
        modelState  n;
        pieceCode   underCursor;
        pieceCode   moving;
        logic [2:0] fileIdx;
        logic [2:0] rankIdx;
        n = s;
        fileIdx = s.cursor[5:3];
        rankIdx = s.cursor[2:0];
        // Left, right, down, up; a blocked step holds the cursor
        if (buttons[0]) begin
            if (fileIdx != 3'd0) begin
                fileIdx = fileIdx - 3'd1;
            end
        end else if (buttons[1]) begin
            if (fileIdx != 3'd7) begin
                fileIdx = fileIdx + 3'd1;
            end
        end else if (buttons[2]) begin
            if (rankIdx != 3'd7) begin
                rankIdx = rankIdx + 3'd1;
            end
        end else if (buttons[3]) begin
            if (rankIdx != 3'd0) begin
                rankIdx = rankIdx - 3'd1;
            end
        end
        n.cursor = {fileIdx, rankIdx};
        // Writer shows place, then clear, then signals done
        n.commit = 1'b0;
        n.done   = 1'b0;
        if (s.phase == 2'd1) begin
            n.phase = 2'd2;
        end else if (s.phase == 2'd2) begin
            n.phase = 2'd0;
            n.done  = 1'b1;
        end else if (s.commit) begin
            n.phase = 2'd1;
        end
        underCursor.raw = squareContent(board, s.cursor);
        moving.raw      = squareContent(board, s.selSq);
        case (s.fsm)
            2'd0: begin
                if (buttons[4] && underCursor.fields.kind != kindEmpty
                        && underCursor.fields.isBlack == s.turn) begin
                    n.sel   = 1'b1;
                    n.selSq = s.cursor;
                    n.fsm   = 2'd1;
                end
            end
            2'd1: begin
                if (buttons[4]) begin
                    n.sel = 1'b0;
                    n.fsm = allow ? 2'd2 : 2'd0;
                    if (allow) begin
                        n.commit = 1'b1;
                        n.target = s.cursor;
                        n.source = s.selSq;
                        // Pawn on the far rank becomes a queen
                        if (moving.fields.kind == kindPawn
                                && s.cursor[2:0] == (moving.fields.isBlack ? 3'd7 : 3'd0)) begin
                            moving.fields.kind = kindQueen;
                        end
                        n.content = moving.raw;
                    end
                end
            end
            default: begin
                if (s.done) begin
                    n.turn = ~s.turn;
                    n.fsm  = 2'd0;
                end
            end
        endcase
        return n;
    endfunction

    task automatic compareValue(input logic [15:0] actual, input logic [15:0] expected,
                                input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic setSquare(input logic [5:0] sq, input logic [3:0] code);
        boardModel[{sq, 2'b00} +: 4] = code;
    endtask

    task automatic loadStartPosition();
        logic [5:0] fileBase;
        boardModel = '0;
        for (int f = 0; f < 8; f++) begin
            fileBase = 6'(f * 8);
            setSquare(fileBase, {1'b1, backRowKind(3'(f))});
            setSquare(fileBase + 6'd1, {1'b1, kindPawn});
            setSquare(fileBase + 6'd6, {1'b0, kindPawn});
            setSquare(fileBase + 6'd7, {1'b0, backRowKind(3'(f))});
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks, all start at a falling edge
    //////////////////////////////////////////////////

    task automatic pressFor(input logic [4:0] buttons, input logic allow, input int cycles);
        {BTNC, BTNU, BTND, BTNR, BTNL} = buttons;
        allowMove = allow;
        repeat (cycles) @(negedge clk);
        {BTNC, BTNU, BTND, BTNR, BTNL} = 5'b00000;
        allowMove = 1'b0;
    endtask

    task automatic moveCursorTo(input logic [5:0] sq);
        int steps;
        steps = 0;
        while (model.cursor != sq && steps < 16) begin
            if (model.cursor[5:3] > sq[5:3]) begin
                pressFor(btnL, 1'b0, 1);
            end else if (model.cursor[5:3] < sq[5:3]) begin
                pressFor(btnR, 1'b0, 1);
            end else if (model.cursor[2:0] < sq[2:0]) begin
                pressFor(btnD, 1'b0, 1);
            end else begin
                pressFor(btnU, 1'b0, 1);
            end
            steps++;
        end
        if (model.cursor != sq) begin
            $display("Cursor did not reach square %0d", sq);
            errorCount++;
        end
    endtask

    task automatic selectSquare(input logic [5:0] sq);
        moveCursorTo(sq);
        pressFor(btnC, 1'b0, 1);
    endtask

    task automatic checkSelection(input logic flag, input logic [5:0] sq, input string what);
        @(negedge clk);
        compareValue(16'(moveData[12:6]), 16'({flag, sq}), what);
    endtask

    // Confirm on target, wait for the turn to change, then look at the board
    task automatic confirmMove(input logic [5:0] source, input logic [5:0] target,
                               input logic [3:0] placed);
        logic turnBefore;
        int   waited;
        turnBefore = moveData[13];
        moveCursorTo(target);
        pressFor(btnC, 1'b1, 1);
        waited = 0;
        while (moveData[13] == turnBefore && waited < 12) begin
            @(negedge clk);
            waited++;
        end
        if (moveData[13] == turnBefore) begin
            $display("Move from %0d to %0d did not hand over the turn", source, target);
            errorCount++;
        end
        compareValue(16'(squareContent(boardModel, target)), 16'(placed), "target square");
        compareValue(16'(squareContent(boardModel, source)), 16'd0, "source square");
    endtask

    //////////////////////////////////////////////////
    // Reference update, comparison and timeout
    //////////////////////////////////////////////////

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            model        = '0;
            model.cursor = startCursor;
            lastModel    = model;
        end else begin
            lastModel = model;
            model     = predictNext(model, {BTNC, BTNU, BTND, BTNR, BTNL}, allowMove,
                                    entireBoard);
        end
    end

    initial begin
        loadStartPosition();
        forever begin
            @(negedge clk);
            if (!reset) begin
                compareValue(16'(moveData), 16'({lastModel.turn, lastModel.sel,
                              lastModel.selSq, lastModel.cursor}), "moveData");
                compareValue(16'(changePiece[changeBits-1]), 16'(model.phase != 2'd0),
                             "write strobe");
                if (model.phase == 2'd1) begin
                    compareValue(16'(changePiece), 16'({1'b1, model.content, model.target}),
                                 "place write");
                end else if (model.phase == 2'd2) begin
                    compareValue(16'(changePiece), 16'({1'b1, 4'h0, model.source}),
                                 "clear write");
                end
                // Board builder side
                if (changePiece[changeBits-1]) begin
                    setSquare(changePiece[5:0], changePiece[9:6]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: no verdict after %0d clock cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        allowMove = 1'b0;
        {BTNC, BTNU, BTND, BTNR, BTNL} = 5'b00000;
        lcgState = 32'd79657;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compareValue(16'(moveData), 16'({2'b00, 6'd0, startCursor}), "moveData after reset");
        compareValue(16'(changePiece[changeBits-1]), 16'd0, "strobe after reset");

        // Clamping at all four edges, then priority with several buttons held
        pressFor(btnL, 1'b0, 9);
        pressFor(btnU, 1'b0, 9);
        pressFor(btnR, 1'b0, 9);
        pressFor(btnD, 1'b0, 9);
        compareValue(16'(moveData[5:0]), 16'd63, "cursor clamped in corner");
        pressFor(btnL | btnR, 1'b0, 3);
        pressFor(btnU | btnD | btnR, 1'b0, 3);

        for (int i = 0; i < randomCycles; i++) begin
            lcgState = lcgNext(lcgState);
            BTNL = (lcgState[17:16] == 2'd0);
            BTNR = (lcgState[19:18] == 2'd0);
            BTND = (lcgState[21:20] == 2'd0);
            BTNU = (lcgState[23:22] == 2'd0);
            @(negedge clk);
        end
        {BTNU, BTND, BTNR, BTNL} = 4'b0000;

        // White: empty square, black piece, then own pawn
        selectSquare(6'd36);
        checkSelection(1'b0, 6'd0, "select on empty square");
        selectSquare(6'd33);
        checkSelection(1'b0, 6'd0, "select on opponent piece");
        selectSquare(6'd38);
        checkSelection(1'b1, 6'd38, "select on own pawn");
        confirmMove(6'd38, 6'd36, {1'b0, kindPawn});

        // Black: rejected move keeps the turn
        selectSquare(6'd9);
        moveCursorTo(6'd10);
        pressFor(btnC, 1'b0, 1);
        repeat (4) @(negedge clk);
        compareValue(16'(moveData[13:12]), 16'b10, "turn and selection after rejection");
        compareValue(16'(squareContent(boardModel, 6'd9)), 16'({1'b1, kindPawn}),
                     "source kept after rejection");

        // Promotions on both sides, then a plain rook move
        selectSquare(6'd9);
        confirmMove(6'd9, 6'd15, {1'b1, kindQueen});
        selectSquare(6'd14);
        confirmMove(6'd14, 6'd8, {1'b0, kindQueen});
        selectSquare(6'd0);
        confirmMove(6'd0, 6'd2, {1'b1, kindRook});

        repeat (2) @(negedge clk);
        $display("Run complete: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/chessUserInput_sva.sv ====
`timescale 1ns/1ps

module chessUserInputSva (
    input logic                            clk,
    input logic                            reset,
    input logic [chessPkg::changeBits-1:0] changePiece
);
    import chessPkg::*;

    logic strobe;

    assign strobe = changePiece[changeBits-1];

    //////////////////////////////////////////////////
    // Board-change strobe
    //////////////////////////////////////////////////

    // Nothing is written straight out of reset
    property quietAfterReset;
        @(posedge clk) $fell(reset) |=> !strobe;
    endproperty

    // A move is one place write and one clear write
    property noThirdStrobe;
        @(posedge clk) disable iff (reset)
            !(strobe && $past(strobe) && $past(strobe, 2));
    endproperty

    // Place write is always followed by the clear write
    property strobeInPairs;
        @(posedge clk) disable iff (reset)
            ($past(strobe) && !$past(strobe, 2)) |-> strobe;
    endproperty

    quietAfterResetCheck: assert property (quietAfterReset)
        else $error("Strobe high right after reset release");
    noThirdStrobeCheck: assert property (noThirdStrobe)
        else $error("Strobe high for three cycles in a row");
    strobeInPairsCheck: assert property (strobeInPairs)
        else $error("Strobe high for a single cycle only");

endmodule

bind chessUserInput chessUserInputSva strobeChecks (
    .clk        (clk),
    .reset      (reset),
    .changePiece(changePiece)
);
